// ==== src/nebula_pkg.sv ====
// Nebula Wishbone fabric shared constants
// Bus widths, team counts, address map and select reset values
package nebula_pkg;

    // Wishbone bus
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 32;
    localparam int WB_SEL_W  = 4;

    // Managers on the shared bus, host first
    localparam int NUM_MANAGERS = 2;
    localparam int MGR_IDX_W    = $clog2(NUM_MANAGERS);

    // Team designs feeding the pad and LA muxes
    localparam int NUM_TEAMS  = 4;
    localparam int TEAM_SEL_W = 4;
    localparam int GPIO_W     = 38;
    localparam int LA_W       = 128;

    // Address map
    localparam logic [15:0] USER_BASE   = 16'h3000; // Upper half of every mapped address
    localparam logic [3:0]  REGION_SRAM = 4'd0;     // Region field is adr[15:12]
    localparam logic [3:0]  REGION_GPIO = 4'd1;
    localparam logic [3:0]  REGION_LA   = 4'd2;

    // SRAM geometry, word index taken from adr[9:2]
    localparam int SRAM_DEPTH = 256;
    localparam int SRAM_AW    = $clog2(SRAM_DEPTH);

    // No team driving the pads or the LA word
    localparam logic [TEAM_SEL_W-1:0] TEAM_SEL_NONE = TEAM_SEL_W'(15);

endpackage

// ==== src/wb_arbiter.sv ====
`timescale 1ns/1ps
// Round-robin Wishbone arbiter
// Registered grant hands the shared bus to one manager until it drops cyc
module wb_arbiter
    import nebula_pkg::*;
(
    input  logic                              wb_clk_i,
    input  logic                              rst_i,

    // Flattened manager ports, manager 0 in the low slot
    input  logic [NUM_MANAGERS-1:0]           m_cyc_i,
    input  logic [NUM_MANAGERS-1:0]           m_stb_i,
    input  logic [NUM_MANAGERS-1:0]           m_we_i,
    input  logic [NUM_MANAGERS*WB_SEL_W-1:0]  m_sel_i,
    input  logic [NUM_MANAGERS*WB_ADDR_W-1:0] m_adr_i,
    input  logic [NUM_MANAGERS*WB_DATA_W-1:0] m_dat_i,
    output logic [NUM_MANAGERS-1:0]           m_ack_o,
    output logic [NUM_MANAGERS*WB_DATA_W-1:0] m_dat_o,

    // Shared bus towards the decoder
    output logic                              bus_cyc_o,
    output logic                              bus_stb_o,
    output logic                              bus_we_o,
    output logic [WB_SEL_W-1:0]               bus_sel_o,
    output logic [WB_ADDR_W-1:0]              bus_adr_o,
    output logic [WB_DATA_W-1:0]              bus_dat_o,
    input  logic                              bus_ack_i,
    input  logic [WB_DATA_W-1:0]              bus_dat_i
);

    logic [MGR_IDX_W-1:0] grant_q;
    logic                 owned_q;
    logic [MGR_IDX_W-1:0] next_grant;
    logic                 next_valid;
    logic                 bus_free;

    // Owner has let go, or nobody holds the bus
    assign bus_free = !owned_q || !m_cyc_i[grant_q];

    // Search starts just after the last manager granted
    always_comb begin
        next_grant = grant_q;
        next_valid = 1'b0;
        for (int k = 1; k <= NUM_MANAGERS; k++) begin
            if (!next_valid && m_cyc_i[(int'(grant_q) + k) % NUM_MANAGERS]) begin
                next_grant = MGR_IDX_W'((int'(grant_q) + k) % NUM_MANAGERS);
                next_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            grant_q <= MGR_IDX_W'(NUM_MANAGERS - 1); // Host wins the first round
            owned_q <= 1'b0;
        end else if (bus_free) begin
            owned_q <= next_valid;
            if (next_valid) begin
                grant_q <= next_grant;
            end
        end
    end

    assign bus_cyc_o = owned_q & m_cyc_i[grant_q];
    assign bus_stb_o = owned_q & m_cyc_i[grant_q] & m_stb_i[grant_q];
    assign bus_we_o  = m_we_i[grant_q];
    assign bus_sel_o = m_sel_i[grant_q*WB_SEL_W +: WB_SEL_W];
    assign bus_adr_o = m_adr_i[grant_q*WB_ADDR_W +: WB_ADDR_W];
    assign bus_dat_o = m_dat_i[grant_q*WB_DATA_W +: WB_DATA_W];

    // Only the owner sees ack and read data
    for (genvar i = 0; i < NUM_MANAGERS; i++) begin : g_ret
        logic granted;
        assign granted    = owned_q && (grant_q == MGR_IDX_W'(i));
        assign m_ack_o[i] = granted & bus_ack_i;
        assign m_dat_o[i*WB_DATA_W +: WB_DATA_W] = granted ? bus_dat_i : '0;
    end

endmodule

// ==== src/wb_decoder.sv ====
`timescale 1ns/1ps
// Wishbone address decoder for SRAM, GPIO and LA control
// Unmapped accesses get a local ack with zero data
module wb_decoder
    import nebula_pkg::*;
(
    input  logic                 wb_clk_i,
    input  logic                 rst_i,

    // Shared bus from the arbiter
    input  logic                 bus_cyc_i,
    input  logic                 bus_stb_i,
    input  logic [WB_ADDR_W-1:0] bus_adr_i,
    output logic                 bus_ack_o,
    output logic [WB_DATA_W-1:0] bus_dat_o,

    // Slave strobes, cyc already folded in
    output logic                 sram_stb_o,
    output logic                 gpio_stb_o,
    output logic                 la_stb_o,
    input  logic                 sram_ack_i,
    input  logic [WB_DATA_W-1:0] sram_dat_i,
    input  logic                 gpio_ack_i,
    input  logic [WB_DATA_W-1:0] gpio_dat_i,
    input  logic                 la_ack_i,
    input  logic [WB_DATA_W-1:0] la_dat_i
);

    logic       req;
    logic       in_user;
    logic [3:0] region;
    logic       hit_sram;
    logic       hit_gpio;
    logic       hit_la;
    logic       unmapped;
    logic       err_ack_q;

    assign req     = bus_cyc_i & bus_stb_i;
    assign in_user = bus_adr_i[31:16] == USER_BASE;
    assign region  = bus_adr_i[15:12];

    assign hit_sram = in_user && (region == REGION_SRAM);
    assign hit_gpio = in_user && (region == REGION_GPIO);
    assign hit_la   = in_user && (region == REGION_LA);
    assign unmapped = !(hit_sram || hit_gpio || hit_la);

    assign sram_stb_o = req & hit_sram;
    assign gpio_stb_o = req & hit_gpio;
    assign la_stb_o   = req & hit_la;

    // One-cycle ack for holes in the map, nothing is touched
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= req & unmapped & ~err_ack_q;
        end
    end

    always_comb begin
        bus_ack_o = err_ack_q;
        bus_dat_o = '0;   // Also the read data of an unmapped access
        if (hit_sram) begin
            bus_ack_o = sram_ack_i;
            bus_dat_o = sram_dat_i;
        end else if (hit_gpio) begin
            bus_ack_o = gpio_ack_i;
            bus_dat_o = gpio_dat_i;
        end else if (hit_la) begin
            bus_ack_o = la_ack_i;
            bus_dat_o = la_dat_i;
        end
    end

endmodule

// ==== src/wb_sram.sv ====
`timescale 1ns/1ps
// Wishbone SRAM, 256 words of 32 bits with byte-select writes
module wb_sram
    import nebula_pkg::*;
(
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [WB_SEL_W-1:0]  sel_i,
    input  logic [WB_ADDR_W-1:0] adr_i,
    input  logic [WB_DATA_W-1:0] dat_i,
    output logic                 ack_o,
    output logic [WB_DATA_W-1:0] dat_o
);

    logic [WB_DATA_W-1:0] mem [SRAM_DEPTH];
    logic [WB_DATA_W-1:0] rdata_q;
    logic [SRAM_AW-1:0]   idx;
    logic                 ack_q;
    logic                 access;

    assign idx    = adr_i[SRAM_AW+1:2];  // Word address
    assign access = stb_i & ~ack_q;      // New request, not the one being acked

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (we_i) begin
                for (int b = 0; b < WB_SEL_W; b++) begin
                    if (sel_i[b]) begin
                        mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign ack_o = ack_q;
    assign dat_o = rdata_q;

endmodule

// ==== src/gpio_control.sv ====
`timescale 1ns/1ps
// GPIO control, team-select register steering one team's outputs and enables to the pads
module gpio_control
    import nebula_pkg::*;
(
    input  logic                           wb_clk_i,
    input  logic                           rst_i,
    input  logic                           stb_i,
    input  logic                           we_i,
    input  logic [WB_DATA_W-1:0]           dat_i,
    output logic                           ack_o,
    output logic [WB_DATA_W-1:0]           dat_o,

    // Team pad drivers, team 0 in the low slice
    input  logic [GPIO_W*NUM_TEAMS-1:0]    designs_gpio_out_i,
    input  logic [GPIO_W*NUM_TEAMS-1:0]    designs_gpio_oeb_i,
    output logic [GPIO_W-1:0]              io_out_o,
    output logic [GPIO_W-1:0]              io_oeb_o
);

    logic [TEAM_SEL_W-1:0] team_sel_q;
    logic                  ack_q;
    logic                  team_valid;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            team_sel_q <= TEAM_SEL_NONE;
        end else begin
            ack_q <= stb_i & ~ack_q;
            if (stb_i && !ack_q && we_i) begin
                team_sel_q <= dat_i[TEAM_SEL_W-1:0];
            end
        end
    end

    assign ack_o = ack_q;
    assign dat_o = {{(WB_DATA_W-TEAM_SEL_W){1'b0}}, team_sel_q};

    // Pads stay tristated unless a real team is picked
    assign team_valid = team_sel_q < NUM_TEAMS;
    assign io_out_o   = team_valid ? designs_gpio_out_i[team_sel_q*GPIO_W +: GPIO_W] : '0;
    assign io_oeb_o   = team_valid ? designs_gpio_oeb_i[team_sel_q*GPIO_W +: GPIO_W] : '1;

endmodule

// ==== src/la_control.sv ====
`timescale 1ns/1ps
// LA control, team-select register choosing the 128-bit logic-analyzer word
module la_control
    import nebula_pkg::*;
(
    input  logic                        wb_clk_i,
    input  logic                        rst_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  logic [WB_DATA_W-1:0]        dat_i,
    output logic                        ack_o,
    output logic [WB_DATA_W-1:0]        dat_o,
    input  logic [LA_W*NUM_TEAMS-1:0]   designs_la_data_i,   // Team 0 in the low word
    output logic [LA_W-1:0]             la_data_out_o
);

    logic [TEAM_SEL_W-1:0] team_sel_q;
    logic                  ack_q;
    logic                  team_valid;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            team_sel_q <= TEAM_SEL_NONE;
        end else begin
            ack_q <= stb_i & ~ack_q;
            if (stb_i && !ack_q && we_i) begin
                team_sel_q <= dat_i[TEAM_SEL_W-1:0];
            end
        end
    end

    assign ack_o = ack_q;
    assign dat_o = {{(WB_DATA_W-TEAM_SEL_W){1'b0}}, team_sel_q}; // Select readback

    assign team_valid    = team_sel_q < NUM_TEAMS;
    assign la_data_out_o = team_valid ? designs_la_data_i[team_sel_q*LA_W +: LA_W] : '0;

endmodule

// ==== src/nebula_top.sv ====
`timescale 1ns/1ps
// Nebula user-area bus fabric
// Two managers share one Wishbone bus to SRAM, GPIO and LA control
module nebula_top
    import nebula_pkg::*;
(
    input  logic                         wb_clk_i,
    input  logic                         rst_i,

    // Host manager
    input  logic                         wbs_cyc_i,
    input  logic                         wbs_stb_i,
    input  logic                         wbs_we_i,
    input  logic [WB_SEL_W-1:0]          wbs_sel_i,
    input  logic [WB_ADDR_W-1:0]         wbs_adr_i,
    input  logic [WB_DATA_W-1:0]         wbs_dat_i,
    output logic                         wbs_ack_o,
    output logic [WB_DATA_W-1:0]         wbs_dat_o,

    // Team manager
    input  logic                         mgr_cyc_i,
    input  logic                         mgr_stb_i,
    input  logic                         mgr_we_i,
    input  logic [WB_SEL_W-1:0]          mgr_sel_i,
    input  logic [WB_ADDR_W-1:0]         mgr_adr_i,
    input  logic [WB_DATA_W-1:0]         mgr_dat_i,
    output logic                         mgr_ack_o,
    output logic [WB_DATA_W-1:0]         mgr_dat_o,

    // Team outputs, flattened with team 0 lowest
    input  logic [GPIO_W*NUM_TEAMS-1:0]  designs_gpio_out_i,
    input  logic [GPIO_W*NUM_TEAMS-1:0]  designs_gpio_oeb_i,
    input  logic [LA_W*NUM_TEAMS-1:0]    designs_la_data_i,

    output logic [GPIO_W-1:0]            io_out_o,
    output logic [GPIO_W-1:0]            io_oeb_o,
    output logic [LA_W-1:0]              la_data_out_o
);

    logic [NUM_MANAGERS-1:0]           m_ack;
    logic [NUM_MANAGERS*WB_DATA_W-1:0] m_dat;

    logic                 bus_cyc;
    logic                 bus_stb;
    logic                 bus_we;
    logic [WB_SEL_W-1:0]  bus_sel;
    logic [WB_ADDR_W-1:0] bus_adr;
    logic [WB_DATA_W-1:0] bus_wdat;
    logic                 bus_ack;
    logic [WB_DATA_W-1:0] bus_rdat;

    logic                 sram_stb;
    logic                 sram_ack;
    logic [WB_DATA_W-1:0] sram_dat;
    logic                 gpio_stb;
    logic                 gpio_ack;
    logic [WB_DATA_W-1:0] gpio_dat;
    logic                 la_stb;
    logic                 la_ack;
    logic [WB_DATA_W-1:0] la_dat;

    assign wbs_ack_o = m_ack[0];
    assign mgr_ack_o = m_ack[1];
    assign wbs_dat_o = m_dat[0 +: WB_DATA_W];
    assign mgr_dat_o = m_dat[WB_DATA_W +: WB_DATA_W];

    wb_arbiter i_arbiter (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .m_cyc_i   ({mgr_cyc_i, wbs_cyc_i}), // Host sits in slot 0
        .m_stb_i   ({mgr_stb_i, wbs_stb_i}),
        .m_we_i    ({mgr_we_i, wbs_we_i}),
        .m_sel_i   ({mgr_sel_i, wbs_sel_i}),
        .m_adr_i   ({mgr_adr_i, wbs_adr_i}),
        .m_dat_i   ({mgr_dat_i, wbs_dat_i}),
        .m_ack_o   (m_ack),
        .m_dat_o   (m_dat),
        .bus_cyc_o (bus_cyc),
        .bus_stb_o (bus_stb),
        .bus_we_o  (bus_we),
        .bus_sel_o (bus_sel),
        .bus_adr_o (bus_adr),
        .bus_dat_o (bus_wdat),
        .bus_ack_i (bus_ack),
        .bus_dat_i (bus_rdat)
    );

    wb_decoder i_decoder (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .bus_cyc_i  (bus_cyc),
        .bus_stb_i  (bus_stb),
        .bus_adr_i  (bus_adr),
        .bus_ack_o  (bus_ack),
        .bus_dat_o  (bus_rdat),
        .sram_stb_o (sram_stb),
        .gpio_stb_o (gpio_stb),
        .la_stb_o   (la_stb),
        .sram_ack_i (sram_ack),
        .sram_dat_i (sram_dat),
        .gpio_ack_i (gpio_ack),
        .gpio_dat_i (gpio_dat),
        .la_ack_i   (la_ack),
        .la_dat_i   (la_dat)
    );

    wb_sram i_sram (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .stb_i    (sram_stb),
        .we_i     (bus_we),
        .sel_i    (bus_sel),
        .adr_i    (bus_adr),
        .dat_i    (bus_wdat),
        .ack_o    (sram_ack),
        .dat_o    (sram_dat)
    );

    gpio_control i_gpio (
        .wb_clk_i           (wb_clk_i),
        .rst_i              (rst_i),
        .stb_i              (gpio_stb),
        .we_i               (bus_we),
        .dat_i              (bus_wdat),
        .ack_o              (gpio_ack),
        .dat_o              (gpio_dat),
        .designs_gpio_out_i (designs_gpio_out_i),
        .designs_gpio_oeb_i (designs_gpio_oeb_i),
        .io_out_o           (io_out_o),
        .io_oeb_o           (io_oeb_o)
    );

    la_control i_la (
        .wb_clk_i          (wb_clk_i),
        .rst_i             (rst_i),
        .stb_i             (la_stb),
        .we_i              (bus_we),
        .dat_i             (bus_wdat),
        .ack_o             (la_ack),
        .dat_o             (la_dat),
        .designs_la_data_i (designs_la_data_i),
        .la_data_out_o     (la_data_out_o)
    );

endmodule

// ==== tb/tb_nebula.sv ====
`timescale 1ns/1ps
// Testbench for the Nebula bus fabric
// Random accesses from both managers checked against a reference model
module tb_nebula
    import nebula_pkg::*;
();

    localparam int SEED        = 30123;
    localparam int ACK_TIMEOUT = 20;   // Cycles to wait for ack under contention

    logic                        wb_clk_i;
    logic                        rst_i;
    logic                        wbs_cyc_i;
    logic                        wbs_stb_i;
    logic                        wbs_we_i;
    logic [WB_SEL_W-1:0]         wbs_sel_i;
    logic [WB_ADDR_W-1:0]        wbs_adr_i;
    logic [WB_DATA_W-1:0]        wbs_dat_i;
    logic                        wbs_ack_o;
    logic [WB_DATA_W-1:0]        wbs_dat_o;
    logic                        mgr_cyc_i;
    logic                        mgr_stb_i;
    logic                        mgr_we_i;
    logic [WB_SEL_W-1:0]         mgr_sel_i;
    logic [WB_ADDR_W-1:0]        mgr_adr_i;
    logic [WB_DATA_W-1:0]        mgr_dat_i;
    logic                        mgr_ack_o;
    logic [WB_DATA_W-1:0]        mgr_dat_o;
    logic [GPIO_W*NUM_TEAMS-1:0] designs_gpio_out_i;
    logic [GPIO_W*NUM_TEAMS-1:0] designs_gpio_oeb_i;
    logic [LA_W*NUM_TEAMS-1:0]   designs_la_data_i;
    logic [GPIO_W-1:0]           io_out_o;
    logic [GPIO_W-1:0]           io_oeb_o;
    logic [LA_W-1:0]             la_data_out_o;

    // Reference model
    logic [WB_DATA_W-1:0]  model_mem [SRAM_DEPTH];
    logic [TEAM_SEL_W-1:0] model_gpio_sel;
    logic [TEAM_SEL_W-1:0] model_la_sel;
    logic [GPIO_W-1:0]     team_gpio_out [NUM_TEAMS];
    logic [GPIO_W-1:0]     team_gpio_oeb [NUM_TEAMS];
    logic [LA_W-1:0]       team_la [NUM_TEAMS];

    int check_count;
    int error_count;
    int timeout_count;

    initial wb_clk_i = 1'b0;
    always #20 wb_clk_i = ~wb_clk_i;

    nebula_top i_dut (.*);

    function automatic logic [WB_ADDR_W-1:0] sram_addr(input int idx);
        return {USER_BASE, REGION_SRAM, 2'b00, 8'(idx), 2'b00};
    endfunction

    // Returns the read data at ack time and applies writes to the model as they land
    function automatic logic [WB_DATA_W-1:0] model_access(input logic we,
            input logic [WB_SEL_W-1:0] sel, input logic [WB_ADDR_W-1:0] adr,
            input logic [WB_DATA_W-1:0] wdat);
        logic [WB_DATA_W-1:0] rd;
        int                   idx;
        rd  = '0;
        idx = int'(adr[9:2]);
        if (adr[31:16] == USER_BASE) begin
            case (adr[15:12])
                REGION_SRAM: begin
                    rd = model_mem[idx];  // Old word since the read precedes the merge
                    for (int b = 0; b < WB_SEL_W; b++) begin
                        if (we && sel[b]) begin
                            model_mem[idx][b*8 +: 8] = wdat[b*8 +: 8];
                        end
                    end
                end
                REGION_GPIO: begin
                    if (we) model_gpio_sel = wdat[TEAM_SEL_W-1:0];
                    rd = WB_DATA_W'(model_gpio_sel);
                end
                REGION_LA: begin
                    if (we) model_la_sel = wdat[TEAM_SEL_W-1:0];
                    rd = WB_DATA_W'(model_la_sel);
                end
                default: rd = '0;  // Hole in the map
            endcase
        end
        return rd;
    endfunction

    task automatic host_access(input logic we, input logic [WB_SEL_W-1:0] sel,
            input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] wdat,
            output logic [WB_DATA_W-1:0] exp_rd, output logic [WB_DATA_W-1:0] act_rd);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        exp_rd = '0;
        act_rd = '0;
        @(negedge wb_clk_i);
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = sel;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        while (!got && cycles < ACK_TIMEOUT) begin
            @(negedge wb_clk_i);
            cycles++;
            if (wbs_ack_o) begin
                got    = 1'b1;
                act_rd = wbs_dat_o;
                exp_rd = model_access(we, sel, adr, wdat);
            end
        end
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        if (!got) begin
            timeout_count++;
            $display("Host manager saw no ack within %0d cycles, address %h", ACK_TIMEOUT, adr);
        end
    endtask

    task automatic team_access(input logic we, input logic [WB_SEL_W-1:0] sel,
            input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] wdat,
            output logic [WB_DATA_W-1:0] exp_rd, output logic [WB_DATA_W-1:0] act_rd);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        exp_rd = '0;
        act_rd = '0;
        @(negedge wb_clk_i);
        mgr_cyc_i = 1'b1;
        mgr_stb_i = 1'b1;
        mgr_we_i  = we;
        mgr_sel_i = sel;
        mgr_adr_i = adr;
        mgr_dat_i = wdat;
        while (!got && cycles < ACK_TIMEOUT) begin
            @(negedge wb_clk_i);
            cycles++;
            if (mgr_ack_o) begin
                got    = 1'b1;
                act_rd = mgr_dat_o;
                exp_rd = model_access(we, sel, adr, wdat);
            end
        end
        mgr_cyc_i = 1'b0;
        mgr_stb_i = 1'b0;
        mgr_we_i  = 1'b0;
        if (!got) begin
            timeout_count++;
            $display("Team manager saw no ack within %0d cycles, address %h", ACK_TIMEOUT, adr);
        end
    endtask

    task automatic bus_access(input int mgr, input logic we, input logic [WB_SEL_W-1:0] sel,
            input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] wdat,
            output logic [WB_DATA_W-1:0] exp_rd, output logic [WB_DATA_W-1:0] act_rd);
        if (mgr == 0) host_access(we, sel, adr, wdat, exp_rd, act_rd);
        else          team_access(we, sel, adr, wdat, exp_rd, act_rd);
    endtask

    task automatic check_word(input string name, input logic [WB_DATA_W-1:0] exp,
            input logic [WB_DATA_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_gpio(input string name, input logic [GPIO_W-1:0] exp_out,
            input logic [GPIO_W-1:0] exp_oeb, input logic [GPIO_W-1:0] act_out,
            input logic [GPIO_W-1:0] act_oeb);
        check_count++;
        if (act_out !== exp_out || act_oeb !== exp_oeb) begin
            error_count++;
            $display("CHECK FAILED %s: expected out %h oeb %h, actual out %h oeb %h",
                     name, exp_out, exp_oeb, act_out, act_oeb);
        end
    endtask

    task automatic check_la(input string name, input logic [LA_W-1:0] exp,
            input logic [LA_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Pads and LA word against the selected team or idle values
    task automatic check_pads(input string name);
        logic [GPIO_W-1:0] exp_out;
        logic [GPIO_W-1:0] exp_oeb;
        logic [LA_W-1:0]   exp_la;
        exp_out = '0;
        exp_oeb = '1;
        exp_la  = '0;
        if (model_gpio_sel < NUM_TEAMS) begin
            exp_out = team_gpio_out[model_gpio_sel];
            exp_oeb = team_gpio_oeb[model_gpio_sel];
        end
        if (model_la_sel < NUM_TEAMS) exp_la = team_la[model_la_sel];
        check_gpio({name, " pads"}, exp_out, exp_oeb, io_out_o, io_oeb_o);
        check_la({name, " la"}, exp_la, la_data_out_o);
    endtask

    task automatic randomize_teams();
        for (int t = 0; t < NUM_TEAMS; t++) begin
            team_gpio_out[t] = {6'($urandom), 32'($urandom)};
            team_gpio_oeb[t] = {6'($urandom), 32'($urandom)};
            team_la[t]       = {32'($urandom), 32'($urandom), 32'($urandom), 32'($urandom)};
            designs_gpio_out_i[t*GPIO_W +: GPIO_W] = team_gpio_out[t];
            designs_gpio_oeb_i[t*GPIO_W +: GPIO_W] = team_gpio_oeb[t];
            designs_la_data_i[t*LA_W +: LA_W]      = team_la[t];
        end
    endtask

    task automatic random_sram_traffic(input int mgr, input int count, input int words);
        logic                 we;
        logic [WB_SEL_W-1:0]  sel;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] exp_rd;
        logic [WB_DATA_W-1:0] act_rd;
        for (int n = 0; n < count; n++) begin
            we  = 1'($urandom);
            sel = WB_SEL_W'($urandom);
            adr = sram_addr($urandom_range(0, words - 1));
            bus_access(mgr, we, sel, adr, $urandom, exp_rd, act_rd);
            if (!we) check_word($sformatf("shared read m%0d %h", mgr, adr), exp_rd, act_rd);
        end
    endtask

    // Select write, readback and pad check for one control block
    task automatic select_test(input string name, input logic [3:0] region, input int rounds);
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] exp_rd;
        logic [WB_DATA_W-1:0] act_rd;
        adr = {USER_BASE, region, 12'h000};
        for (int n = 0; n < rounds; n++) begin
            randomize_teams();
            bus_access(n % 2, 1'b1, '1, adr, $urandom, exp_rd, act_rd);
            bus_access((n + 1) % 2, 1'b0, '1, adr, '0, exp_rd, act_rd);
            check_word({name, " select readback"}, exp_rd, act_rd);
            check_pads(name);
        end
    endtask

    initial begin
        int unsigned          seed_val;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] exp_rd;
        logic [WB_DATA_W-1:0] act_rd;
        logic [15:0]          upper;

        seed_val      = $urandom(SEED);
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        rst_i     = 1'b1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = '0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        mgr_cyc_i = 1'b0;
        mgr_stb_i = 1'b0;
        mgr_we_i  = 1'b0;
        mgr_sel_i = '0;
        mgr_adr_i = '0;
        mgr_dat_i = '0;
        model_gpio_sel = TEAM_SEL_NONE;
        model_la_sel   = TEAM_SEL_NONE;
        randomize_teams();
        repeat (4) @(negedge wb_clk_i);
        rst_i = 1'b0;

        // Reset state
        check_pads("reset");
        check_ack("reset host ack", 1'b0, wbs_ack_o);
        check_ack("reset team ack", 1'b0, mgr_ack_o);

        // Fill the SRAM so every word is known
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            host_access(1'b1, '1, sram_addr(i), $urandom, exp_rd, act_rd);
        end

        // Byte writes from the host with a readback after each
        for (int n = 0; n < 60; n++) begin
            adr = sram_addr($urandom_range(0, SRAM_DEPTH - 1));
            host_access(1'b1, WB_SEL_W'($urandom), adr, $urandom, exp_rd, act_rd);
            host_access(1'b0, '1, adr, '0, exp_rd, act_rd);
            check_word($sformatf("byte write readback %h", adr), exp_rd, act_rd);
        end

        // Both managers at once on a small window of words
        fork
            random_sram_traffic(0, 40, 16);
            random_sram_traffic(1, 40, 16);
        join

        select_test("gpio", REGION_GPIO, 16);
        select_test("la", REGION_LA, 16);

        // Unmapped accesses alternate between empty regions and foreign upper halves
        for (int n = 0; n < 16; n++) begin
            if (n % 2 == 0) begin
                adr = {USER_BASE, 4'($urandom_range(3, 15)), 12'($urandom)};
            end else begin
                upper = 16'($urandom);
                if (upper == USER_BASE) upper = upper ^ 16'h0100;
                adr = {upper, 16'($urandom)};
            end
            bus_access(n % 2, 1'b1, '1, adr, $urandom, exp_rd, act_rd);
            bus_access((n + 1) % 2, 1'b0, '1, adr, '0, exp_rd, act_rd);
            check_word($sformatf("unmapped read %h", adr), exp_rd, act_rd);
        end
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            host_access(1'b0, '1, sram_addr(i), '0, exp_rd, act_rd);
            check_word($sformatf("final sram word %0d", i), exp_rd, act_rd);
        end
        host_access(1'b0, '1, {USER_BASE, REGION_GPIO, 12'h000}, '0, exp_rd, act_rd);
        check_word("final gpio select", exp_rd, act_rd);
        host_access(1'b0, '1, {USER_BASE, REGION_LA, 12'h000}, '0, exp_rd, act_rd);
        check_word("final la select", exp_rd, act_rd);
        check_pads("final");

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== nebula_bus.f ====
src/nebula_pkg.sv
src/wb_arbiter.sv
src/wb_decoder.sv
src/wb_sram.sv
src/gpio_control.sv
src/la_control.sv
src/nebula_top.sv
tb/tb_nebula.sv

// ==== Bender.yml ====
package:
  name: nebula_bus

sources:
  - src/nebula_pkg.sv
  - src/wb_arbiter.sv
  - src/wb_decoder.sv
  - src/wb_sram.sv
  - src/gpio_control.sv
  - src/la_control.sv
  - src/nebula_top.sv
  - target: test
    files:
      - tb/tb_nebula.sv
